/* rtl/mbfPkg.sv */
`default_nettype none

package mbfPkg;

    localparam int unsigned mbfWidth   = 128;  // 7-variable MBF
    localparam int unsigned sumWidth   = 48;
    localparam int unsigned countWidth = 13;
    localparam int unsigned queueDepth = 8;
    localparam int unsigned pipeDepth  = 3;    // stage 1, stage 2, accumulator

    // one input beat with two bottoms side by side
    typedef struct packed {
        logic                startNewTop;  // lane A carries the new top
        logic [mbfWidth-1:0] botA;
        logic [mbfWidth-1:0] botB;
    } inBeat;

    typedef struct packed {
        logic                  eccStatus;    // reserved and kept zero
        logic [1:0]            spare;
        logic [countWidth-1:0] pcoeffCount;
        logic [sumWidth-1:0]   summedData;
    } botRecord;

    // occupancy of the pipeline for the top that just ended
    typedef struct packed {
        logic [31:0] activeCycles;
        logic [31:0] totalCycles;
    } topRecord;

    typedef union packed {
        botRecord bot;
        topRecord top;
    } resultWord;

    typedef struct packed {
        logic      isTop;  // selects the topRecord view of laneA
        resultWord laneA;
        resultWord laneB;
    } outBeat;

endpackage

`default_nettype wire

/* rtl/subsetCounter.sv */
`default_nettype none

module subsetCounter (
    input  wire                              clock,
    input  wire                              rst,
    input  wire  [mbfPkg::mbfWidth-1:0]      top,
    input  wire  [mbfPkg::mbfWidth-1:0]      bot,
    input  wire                              advance,
    output logic                             contained,
    output logic [7:0]                       missing
);

    logic [mbfPkg::mbfWidth-1:0] lackWord;     // top bits the bottom does not have
    logic                        outside;      // bottom has a bit the top lacks
    logic                        stage1Valid;

    function automatic logic [7:0] popCount(input logic [mbfPkg::mbfWidth-1:0] word);
        logic [7:0] total;
        total = '0;
        for (int i = 0; i < mbfPkg::mbfWidth; i++) begin
            total = total + {7'd0, word[i]};
        end
        return total;
    endfunction

    // stage 1 compares against the current top
    always_ff @(posedge clock) begin
        if (advance) begin
            lackWord <= top & ~bot;
            outside  <= |(bot & ~top);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            stage1Valid <= 1'b0;
        end else begin
            stage1Valid <= advance;
        end
    end

    // stage 2 turns the stage 1 word into a flag and a bit count
    always_ff @(posedge clock) begin
        if (stage1Valid) begin
            contained <= !outside;
            missing   <= popCount(lackWord);  // at most 128 so it fits 8 bits
        end
    end

endmodule

`default_nettype wire

/* rtl/laneAccumulator.sv */
`default_nettype none

module laneAccumulator (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     stageValid,
    input  wire                     isTop,
    input  wire                     contained,
    input  wire  [7:0]              missing,
    output mbfPkg::botRecord        record
);

    mbfPkg::botRecord                nextRecord;
    logic [mbfPkg::sumWidth-1:0]     missingWide;

    assign missingWide = {{(mbfPkg::sumWidth - 8){1'b0}}, missing};

    always_comb begin
        nextRecord = record;  // non-contained bottom keeps the totals
        if (isTop) begin
            nextRecord = '0;  // new top starts the totals over
        end else if (contained) begin
            nextRecord.pcoeffCount = record.pcoeffCount
                                   + {{(mbfPkg::countWidth - 1){1'b0}}, 1'b1};
            nextRecord.summedData  = record.summedData + missingWide;
        end
        nextRecord.eccStatus = 1'b0;
        nextRecord.spare     = 2'b00;
    end

    // the record register is the last pipeline stage
    always_ff @(posedge clock) begin
        if (!rst) begin
            record <= '0;
        end else if (stageValid) begin
            record <= nextRecord;
        end
    end

endmodule

`default_nettype wire

/* rtl/occupancyCounter.sv */
`default_nettype none

module occupancyCounter (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     accepted,
    input  wire                     acceptedTop,
    output mbfPkg::topRecord        snapshot
);

    logic [31:0] activeCycles;  // accepted bottom beats since the last top
    logic [31:0] totalCycles;

    always_ff @(posedge clock) begin
        if (!rst) begin
            activeCycles <= '0;
            totalCycles  <= '0;
        end else if (acceptedTop) begin
            activeCycles <= '0;
            totalCycles  <= 32'd1;  // the top beat's own cycle
        end else begin
            totalCycles <= totalCycles + 32'd1;
            if (accepted) begin
                activeCycles <= activeCycles + 32'd1;
            end
        end
    end

    // counts as they stood just before the restart
    always_ff @(posedge clock) begin
        if (acceptedTop) begin
            snapshot.activeCycles <= activeCycles;
            snapshot.totalCycles  <= totalCycles;
        end
    end

endmodule

`default_nettype wire

/* rtl/outputQueue.sv */
`default_nettype none

module outputQueue (
    input  wire                     clock,
    input  wire                     rst,
    input  wire                     writeValid,
    input  mbfPkg::outBeat          writeData,
    input  wire  [1:0]              inFlight,
    input  wire                     outReady,
    output logic                    outValid,
    output mbfPkg::outBeat          outData,
    output logic                    inReady
);

    mbfPkg::outBeat                             mem [mbfPkg::queueDepth];
    logic [$clog2(mbfPkg::queueDepth)-1:0]      rdPtr;
    logic [$clog2(mbfPkg::queueDepth)-1:0]      wrPtr;
    logic [$clog2(mbfPkg::queueDepth):0]        count;
    logic [$clog2(mbfPkg::queueDepth)+1:0]      credit;       // queued plus in flight
    logic [$clog2(mbfPkg::queueDepth)+1:0]      creditLimit;
    logic                                       pop;

    assign outValid = (count != '0);
    assign outData  = mem[rdPtr];
    assign pop      = outValid && outReady;

    // every item in the pipeline already holds a slot
    assign credit      = {1'b0, count} + {{($clog2(mbfPkg::queueDepth)){1'b0}}, inFlight};
    assign creditLimit = mbfPkg::queueDepth[$clog2(mbfPkg::queueDepth)+1:0];
    assign inReady     = (credit < creditLimit);

    always_ff @(posedge clock) begin
        if (writeValid) begin
            mem[wrPtr] <= writeData;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (writeValid) begin
                wrPtr <= wrPtr + 1'b1;  // power of two depth wraps by itself
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({writeValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/fullPermutePipeline.sv */
`default_nettype none

module fullPermutePipeline (
    input  wire                     clock,
    input  wire                     rst,
    input  mbfPkg::inBeat           inData,
    input  wire                     inValid,
    output logic                    inReady,
    output mbfPkg::outBeat          outData,
    output logic                    outValid,
    input  wire                     outReady
);

    logic                               accepted;
    logic                               acceptedTop;
    logic [mbfPkg::mbfWidth-1:0]        topReg;
    logic [mbfPkg::pipeDepth-1:0]       stageValid;  // bit 0 is stage 1
    logic [mbfPkg::pipeDepth-1:0]       stageTop;
    logic [1:0]                         inFlight;
    logic                               containedA;
    logic                               containedB;
    logic [7:0]                         missingA;
    logic [7:0]                         missingB;
    mbfPkg::botRecord                   recordA;
    mbfPkg::botRecord                   recordB;
    mbfPkg::topRecord                   snapshot;
    mbfPkg::topRecord                   snapStage2;
    mbfPkg::topRecord                   snapStage3;
    mbfPkg::outBeat                     writeBeat;

    assign accepted    = inValid && inReady;
    assign acceptedTop = accepted && inData.startNewTop;

    // new top is visible to the bottom accepted right after it
    always_ff @(posedge clock) begin
        if (!rst) begin
            topReg <= '0;
        end else if (acceptedTop) begin
            topReg <= inData.botA;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            stageValid <= '0;
            stageTop   <= '0;
        end else begin
            stageValid <= {stageValid[mbfPkg::pipeDepth-2:0], accepted};
            stageTop   <= {stageTop[mbfPkg::pipeDepth-2:0], acceptedTop};
        end
    end

    // snapshot lands at stage 1 and walks to the last stage
    always_ff @(posedge clock) begin
        snapStage2 <= snapshot;
        snapStage3 <= snapStage2;
    end

    always_comb begin
        inFlight = '0;
        for (int i = 0; i < mbfPkg::pipeDepth; i++) begin
            inFlight = inFlight + {1'b0, stageValid[i]};
        end
    end

    subsetCounter laneACounter (.clock(clock), .rst(rst), .top(topReg), .bot(inData.botA),
        .advance(accepted), .contained(containedA), .missing(missingA));
    subsetCounter laneBCounter (.clock(clock), .rst(rst), .top(topReg), .bot(inData.botB),
        .advance(accepted), .contained(containedB), .missing(missingB));

    laneAccumulator laneAAccum (.clock(clock), .rst(rst), .stageValid(stageValid[1]),
        .isTop(stageTop[1]), .contained(containedA), .missing(missingA), .record(recordA));
    laneAccumulator laneBAccum (.clock(clock), .rst(rst), .stageValid(stageValid[1]),
        .isTop(stageTop[1]), .contained(containedB), .missing(missingB), .record(recordB));

    occupancyCounter occupancy (.clock(clock), .rst(rst), .accepted(accepted),
        .acceptedTop(acceptedTop), .snapshot(snapshot));

    always_comb begin
        writeBeat.isTop = stageTop[mbfPkg::pipeDepth-1];
        if (writeBeat.isTop) begin
            writeBeat.laneA.top = snapStage3;
            writeBeat.laneB     = '0;
        end else begin
            writeBeat.laneA.bot = recordA;
            writeBeat.laneB.bot = recordB;
        end
    end

    outputQueue queue (.clock(clock), .rst(rst), .writeValid(stageValid[mbfPkg::pipeDepth-1]),
        .writeData(writeBeat), .inFlight(inFlight), .outReady(outReady),
        .outValid(outValid), .outData(outData), .inReady(inReady));

endmodule

`default_nettype wire

/* tests/fullPermutePipeline_assert.sv */
`default_nettype none

module queueProtocolChecks (
    input wire                                  clock,
    input wire                                  rst,
    input wire                                  writeValid,
    input wire                                  outReady,
    input wire                                  outValid,
    input wire mbfPkg::outBeat                  outData,
    input wire [$clog2(mbfPkg::queueDepth):0]   count
);
    timeunit 1ns;
    timeprecision 1ps;

    // queue is empty in the cycle after any reset cycle
    resetEmpty: assert property (@(posedge clock) !rst |=> !outValid)
        else $error("outValid was high in the cycle after reset");

    heldOutput: assert property (@(posedge clock) disable iff (!rst)
        outValid && !outReady |=> outValid && $stable(outData))
        else $error("outData changed while a beat waited for outReady");

    // the credit rule keeps every write clear of a full queue
    noFullWrite: assert property (@(posedge clock) disable iff (!rst)
        writeValid |-> 32'(count) < mbfPkg::queueDepth)
        else $error("queue written while it held queueDepth entries");

endmodule

bind outputQueue queueProtocolChecks protocolChecks (
    .clock(clock),
    .rst(rst),
    .writeValid(writeValid),
    .outReady(outReady),
    .outValid(outValid),
    .outData(outData),
    .count(count)
);

`default_nettype wire

/* tests/fullPermutePipelineTb.sv */
`default_nettype none

module fullPermutePipelineTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numEntries    = 64;
    localparam int timeoutCycles = numEntries * 12 + 40;

    typedef struct packed {
        logic                                startNewTop;
        logic [mbfPkg::mbfWidth-1:0]         botA;
        logic [mbfPkg::mbfWidth-1:0]         botB;
        logic [mbfPkg::countWidth-1:0]       countA;
        logic [mbfPkg::sumWidth-1:0]         sumA;
        logic [mbfPkg::countWidth-1:0]       countB;
        logic [mbfPkg::sumWidth-1:0]         sumB;
        logic [31:0]                         activeCycles;  // bottoms since the previous top
    } tableEntry;

    logic               clock;
    logic               rst;
    mbfPkg::inBeat      inData;
    logic               inValid;
    logic               inReady;
    mbfPkg::outBeat     outData;
    logic               outValid;
    logic               outReady;

    tableEntry          stimTable [numEntries];
    logic [31:0]        lfsrState     = 32'h95427fc4;
    int                 errorCount    = 0;
    int                 sentCount     = 0;
    int                 receivedCount = 0;
    int                 cycleCount    = 0;
    logic               anyAccepted   = 1'b0;

    fullPermutePipeline DUT (
        .clock(clock),
        .rst(rst),
        .inData(inData),
        .inValid(inValid),
        .inReady(inReady),
        .outData(outData),
        .outValid(outValid),
        .outReady(outReady)
    );

    function automatic logic [31:0] galoisStep(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;  // x^32 + x^22 + x^2 + x + 1
        end
        return next;
    endfunction

    task automatic takeBits(input int nBits, output logic [mbfPkg::mbfWidth-1:0] bits);
        bits = '0;
        for (int i = 0; i < nBits; i++) begin
            lfsrState = galoisStep(lfsrState);
            bits[i]   = lfsrState[0];
        end
    endtask

    function automatic logic [mbfPkg::mbfWidth-1:0] topConstant(input int idx);
        case (idx)
            0:       return 128'hffff_ffff_fffe_fee8_fee8_e880_8000_0000;
            20:      return 128'hfffc_fff0_ffc0_ff00_fc00_f000_c000_0000;
            default: return 128'hff00_ff00_f0f0_f0f0_cccc_cccc_aaaa_0000;
        endcase
    endfunction

    task automatic makeBottom(input logic [mbfPkg::mbfWidth-1:0] topWord, input logic outsideBit,
                              output logic [mbfPkg::mbfWidth-1:0] bottom);
        logic [mbfPkg::mbfWidth-1:0] bits;
        logic [6:0]                  pos;
        takeBits(mbfPkg::mbfWidth, bits);
        bottom = topWord & bits;
        if (outsideBit) begin
            takeBits(7, bits);
            pos = bits[6:0];
            while (topWord[pos]) begin
                pos = pos + 7'd1;  // walk to the next bit the top lacks
            end
            bottom[pos] = 1'b1;
        end
    endtask

    // a contained bottom adds one to the count and its missing top bits to the sum
    task automatic accumulateLane(input logic [mbfPkg::mbfWidth-1:0] topWord,
                                  input logic [mbfPkg::mbfWidth-1:0] bottom,
                                  inout logic [mbfPkg::countWidth-1:0] count,
                                  inout logic [mbfPkg::sumWidth-1:0] sum);
        if ((bottom & ~topWord) == '0) begin
            count = count + 13'd1;
            sum   = sum + 48'($countones(topWord & ~bottom));
        end
    endtask

    task automatic buildTable();
        logic [mbfPkg::mbfWidth-1:0]   topWord;
        logic [mbfPkg::mbfWidth-1:0]   bottom;
        logic [mbfPkg::countWidth-1:0] countA;
        logic [mbfPkg::countWidth-1:0] countB;
        logic [mbfPkg::sumWidth-1:0]   sumA;
        logic [mbfPkg::sumWidth-1:0]   sumB;
        int                            bottomsSinceTop;
        int                            bottomNumber;
        tableEntry                     entry;
        topWord         = '0;
        countA          = '0;
        countB          = '0;
        sumA            = '0;
        sumB            = '0;
        bottomsSinceTop = 0;
        bottomNumber    = 0;
        for (int i = 0; i < numEntries; i++) begin
            entry = '0;
            if (i == 0 || i == 20 || i == 41) begin
                entry.startNewTop  = 1'b1;
                entry.botA         = topConstant(i);
                takeBits(mbfPkg::mbfWidth, bottom);
                entry.botB         = bottom;  // lane B of a top beat carries no meaning
                entry.activeCycles = 32'(bottomsSinceTop);
                topWord            = entry.botA;
                countA             = '0;
                countB             = '0;
                sumA               = '0;
                sumB               = '0;
                bottomsSinceTop    = 0;
            end else begin
                makeBottom(topWord, (bottomNumber % 5) == 4, bottom);
                entry.botA = bottom;
                bottomNumber++;
                makeBottom(topWord, (bottomNumber % 5) == 4, bottom);
                entry.botB = bottom;
                bottomNumber++;
                accumulateLane(topWord, entry.botA, countA, sumA);
                accumulateLane(topWord, entry.botB, countB, sumB);
                entry.countA = countA;
                entry.sumA   = sumA;
                entry.countB = countB;
                entry.sumB   = sumB;
                bottomsSinceTop++;
            end
            stimTable[i] = entry;
        end
    endtask

    task automatic checkBeat(input int idx, input mbfPkg::outBeat beat);
        tableEntry expected;
        int        entryErrors;
        expected    = stimTable[idx];
        entryErrors = 0;
        assert (beat.isTop == expected.startNewTop) else begin
            $display("Fail entry %0d: isTop expected %h got %h", idx, expected.startNewTop,
                     beat.isTop);
            entryErrors++;
        end
        if (expected.startNewTop) begin
            assert (beat.laneA.top.activeCycles == expected.activeCycles) else begin
                $display("Fail entry %0d: activeCycles expected %h got %h", idx,
                         expected.activeCycles, beat.laneA.top.activeCycles);
                entryErrors++;
            end
            assert (beat.laneA.top.totalCycles >= beat.laneA.top.activeCycles) else begin
                $display("Fail entry %0d: totalCycles %h is below activeCycles %h", idx,
                         beat.laneA.top.totalCycles, beat.laneA.top.activeCycles);
                entryErrors++;
            end
            assert (beat.laneB == '0) else begin
                $display("Fail entry %0d: laneB expected %h got %h", idx, 64'h0, beat.laneB);
                entryErrors++;
            end
        end else begin
            assert (beat.laneA.bot.pcoeffCount == expected.countA) else begin
                $display("Fail entry %0d: laneA.pcoeffCount expected %h got %h", idx,
                         expected.countA, beat.laneA.bot.pcoeffCount);
                entryErrors++;
            end
            assert (beat.laneA.bot.summedData == expected.sumA) else begin
                $display("Fail entry %0d: laneA.summedData expected %h got %h", idx,
                         expected.sumA, beat.laneA.bot.summedData);
                entryErrors++;
            end
            assert (beat.laneB.bot.pcoeffCount == expected.countB) else begin
                $display("Fail entry %0d: laneB.pcoeffCount expected %h got %h", idx,
                         expected.countB, beat.laneB.bot.pcoeffCount);
                entryErrors++;
            end
            assert (beat.laneB.bot.summedData == expected.sumB) else begin
                $display("Fail entry %0d: laneB.summedData expected %h got %h", idx,
                         expected.sumB, beat.laneB.bot.summedData);
                entryErrors++;
            end
            // eccStatus and the spare bits are reserved zero
            assert ({beat.laneA.bot.eccStatus, beat.laneA.bot.spare} == 3'b000) else begin
                $display("Fail entry %0d: laneA eccStatus and spare expected %h got %h", idx,
                         3'b000, {beat.laneA.bot.eccStatus, beat.laneA.bot.spare});
                entryErrors++;
            end
            assert ({beat.laneB.bot.eccStatus, beat.laneB.bot.spare} == 3'b000) else begin
                $display("Fail entry %0d: laneB eccStatus and spare expected %h got %h", idx,
                         3'b000, {beat.laneB.bot.eccStatus, beat.laneB.bot.spare});
                entryErrors++;
            end
        end
        errorCount += entryErrors;
        $display("entry %0d (%s): %0d mismatches", idx,
                 expected.startNewTop ? "top" : "bottom", entryErrors);
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin : watchdog
        while (cycleCount < timeoutCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("Simulation failed");
        $finish;
    end

    // outputs are sampled at the falling edge where they have settled
    initial begin : monitor
        int sinceAccept;
        sinceAccept = 0;
        @(posedge clock);
        forever begin
            @(negedge clock);
            if (anyAccepted) begin
                sinceAccept++;
            end
            if (!anyAccepted || sinceAccept <= 3) begin
                assert (!outValid) else begin
                    $display("outValid rose before the first beat could reach the output");
                    errorCount++;
                end
            end
            if (!anyAccepted) begin
                assert (inReady) else begin
                    $display("inReady was low while the pipeline and queue were empty");
                    errorCount++;
                end
            end
            if (outValid && outReady) begin
                assert (receivedCount < sentCount) else begin
                    $display("an output beat arrived with no accepted input left to match it");
                    errorCount++;
                end
                if (receivedCount < numEntries) begin
                    checkBeat(receivedCount, outData);
                end
                receivedCount++;
            end
        end
    end

    initial begin : stimulus
        int                          sendIdx;
        logic                        inFire;
        logic                        sawBackPressure;
        logic [mbfPkg::mbfWidth-1:0] bits;
        sendIdx         = 0;
        sawBackPressure = 1'b0;
        rst             = 1'b0;
        inData          = '0;
        inValid         = 1'b0;
        outReady        = 1'b0;
        buildTable();
        repeat (10) @(posedge clock);
        #1;
        rst = 1'b1;
        while (receivedCount < numEntries) begin
            @(negedge clock);
            inFire = inValid && inReady;  // transfer at the coming edge
            if (inValid && !inReady) begin
                sawBackPressure = 1'b1;
            end
            @(posedge clock);
            #1;
            if (inFire) begin
                sendIdx++;
                sentCount   = sendIdx;
                anyAccepted = 1'b1;
            end
            if (!inValid || inFire) begin  // a waiting beat stays on the bus
                inValid = 1'b0;
                if (sendIdx < numEntries) begin
                    takeBits(2, bits);
                    if (bits[1:0] != 2'b00) begin
                        inData.startNewTop = stimTable[sendIdx].startNewTop;
                        inData.botA        = stimTable[sendIdx].botA;
                        inData.botB        = stimTable[sendIdx].botB;
                        inValid            = 1'b1;
                    end
                end
            end
            takeBits(2, bits);
            outReady = (bits[1:0] != 2'b00);  // stall one cycle in four
            if (cycleCount >= 40 && cycleCount < 60) begin
                outReady = 1'b0;  // long stall fills the queue until inReady falls
            end
        end
        inValid  = 1'b0;
        outReady = 1'b1;
        repeat (8) @(posedge clock);  // room for any duplicate to show up
        assert (receivedCount == sentCount) else begin
            $display("received %0d beats but %0d were sent", receivedCount, sentCount);
            errorCount++;
        end
        assert (sawBackPressure) else begin
            $display("inReady never fell while a beat was waiting on a full queue");
            errorCount++;
        end
        $display("%0d entries checked, %0d errors, %0d beats sent, %0d received",
                 numEntries, errorCount, sentCount, receivedCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/mbfPkg.sv
rtl/subsetCounter.sv
rtl/laneAccumulator.sv
rtl/occupancyCounter.sv
rtl/outputQueue.sv
rtl/fullPermutePipeline.sv
tests/fullPermutePipeline_assert.sv
tests/fullPermutePipelineTb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module fullPermutePipelineTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VfullPermutePipelineTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
